//--- hw/exu_pkg.sv
package exu_pkg;

   localparam int XLEN     = 32;          // Data path width
   localparam int GHR_SIZE = 8;           // Global history length

   // Bit positions inside a bypass select
   localparam int BYP_R     = 0;
   localparam int BYP_LSU_M = 1;
   localparam int BYP_X     = 2;

   typedef logic [XLEN-1:0]     data_t;   // Operand or result
   typedef logic [31:1]         pc_t;     // Bit 0 always zero
   typedef logic [12:1]         brimm_t;  // Branch offset
   typedef logic [GHR_SIZE-1:0] ghr_t;
   typedef logic [2:0]          byp_sel_t; // One-hot {x, lsu m, r}

   typedef enum logic [3:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLT,
      OP_SLTU,
      OP_SLL,
      OP_SRL,
      OP_SRA,
      OP_BEQ,
      OP_BNE,
      OP_BLT,
      OP_BGE,
      OP_JAL
   } alu_op_t;

   typedef struct packed {
      logic    valid;
      alu_op_t op;
      logic    pred_taken;                // Predicted taken from fetch
   } alu_pkt_t;

   typedef struct packed {
      logic valid;
      logic rs1_sign;                     // Treat rs1 as signed
      logic rs2_sign;                     // Treat rs2 as signed
      logic low;                          // Low half of product
   } mul_pkt_t;

   typedef struct packed {
      byp_sel_t rs1_byp;
      byp_sel_t rs2_byp;
      logic     rs1_en;
      logic     rs2_en;
      logic     select_pc;                // PC into rs1
   } opnd_ctl_t;

   typedef struct packed {
      logic valid;
      logic taken;
      logic mispredict;
      ghr_t ghr;                          // History after update
   } br_report_t;

endpackage

//--- hw/exu_operand_sel.sv
`timescale 1ns/10ps

module exu_operand_sel (
   input  exu_pkg::opnd_ctl_t i_opnd,
   input  exu_pkg::data_t     i_gpr_rs1,
   input  exu_pkg::data_t     i_gpr_rs2,
   input  exu_pkg::data_t     i_immed,
   input  exu_pkg::data_t     i_result_r,
   input  exu_pkg::data_t     i_lsu_result_m,
   input  exu_pkg::data_t     i_result_x,
   input  exu_pkg::pc_t       i_pc,
   output exu_pkg::data_t     o_rs1,
   output exu_pkg::data_t     o_rs2
);

   import exu_pkg::*;

   data_t rs1_byp_data;
   data_t rs2_byp_data;
   logic  rs1_byp_en;
   logic  rs2_byp_en;

   // AND-OR mux of the forwarded results
   function automatic data_t byp_mux(
      input byp_sel_t sel,
      input data_t    res_r,
      input data_t    res_m,
      input data_t    res_x
   );
      return ({XLEN{sel[BYP_R]}}     & res_r) |
             ({XLEN{sel[BYP_LSU_M]}} & res_m) |
             ({XLEN{sel[BYP_X]}}     & res_x);
   endfunction

   assign rs1_byp_en   = |i_opnd.rs1_byp;
   assign rs2_byp_en   = |i_opnd.rs2_byp;
   assign rs1_byp_data = byp_mux(i_opnd.rs1_byp, i_result_r, i_lsu_result_m, i_result_x);
   assign rs2_byp_data = byp_mux(i_opnd.rs2_byp, i_result_r, i_lsu_result_m, i_result_x);

   always_comb begin
      if (rs1_byp_en) begin
         o_rs1 = rs1_byp_data;
      end else if (i_opnd.select_pc) begin
         o_rs1 = {i_pc, 1'b0};            // Link and AUIPC style base
      end else if (i_opnd.rs1_en) begin
         o_rs1 = i_gpr_rs1;
      end else begin
         o_rs1 = '0;
      end
   end

   always_comb begin
      if (rs2_byp_en) begin
         o_rs2 = rs2_byp_data;
      end else if (i_opnd.rs2_en) begin
         o_rs2 = i_gpr_rs2;
      end else begin
         o_rs2 = i_immed;                 // I-type operand
      end
   end

   a_rs1_byp_onehot: assert final ($onehot0(i_opnd.rs1_byp))
      else $error("rs1 bypass select has more than one source");
   a_rs2_byp_onehot: assert final ($onehot0(i_opnd.rs2_byp))
      else $error("rs2 bypass select has more than one source");

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/10ps

module exu_alu (
   input  logic              clk,
   input  logic              i_reset,
   input  exu_pkg::alu_pkt_t i_alu,
   input  exu_pkg::data_t    i_rs1,
   input  exu_pkg::data_t    i_rs2,
   input  exu_pkg::pc_t      i_pc,
   input  exu_pkg::brimm_t   i_br_immed,
   input  logic              i_flush_lower,
   output exu_pkg::data_t    o_result_x,
   output exu_pkg::pc_t      o_pc_x,
   output logic              o_br_valid_x,
   output logic              o_br_taken_x,
   output logic              o_flush_upper_x,
   output exu_pkg::pc_t      o_flush_path_x
);

   import exu_pkg::*;

   logic    valid_x;
   alu_op_t op_x;
   logic    pred_taken_x;
   data_t   a_x;
   data_t   b_x;
   pc_t     pc_x;
   brimm_t  brimm_x;

   pc_t     pc_next_x;
   pc_t     target_x;
   logic    is_branch_x;
   logic    br_valid_x;
   logic    eq_x;
   logic    lt_x;
   logic    taken_x;
   logic    mispredict_x;
   logic    [4:0] shamt_x;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         valid_x <= 1'b0;
      end else begin
         valid_x <= i_alu.valid;
      end
   end

   always_ff @(posedge clk) begin
      op_x         <= i_alu.op;
      pred_taken_x <= i_alu.pred_taken;
      a_x          <= i_rs1;
      b_x          <= i_rs2;
      pc_x         <= i_pc;
      brimm_x      <= i_br_immed;
   end

   assign shamt_x   = b_x[4:0];
   assign eq_x      = (a_x == b_x);
   assign lt_x      = ($signed(a_x) < $signed(b_x));
   assign pc_next_x = pc_x + 31'd2;                       // PC + 4 in halfwords
   assign target_x  = pc_x + {{19{brimm_x[12]}}, brimm_x};

   always_comb begin
      case (op_x)
         OP_ADD:  o_result_x = a_x + b_x;
         OP_SUB:  o_result_x = a_x - b_x;
         OP_AND:  o_result_x = a_x & b_x;
         OP_OR:   o_result_x = a_x | b_x;
         OP_XOR:  o_result_x = a_x ^ b_x;
         OP_SLT:  o_result_x = {{(XLEN-1){1'b0}}, lt_x};
         OP_SLTU: o_result_x = {{(XLEN-1){1'b0}}, (a_x < b_x)};
         OP_SLL:  o_result_x = a_x << shamt_x;
         OP_SRL:  o_result_x = a_x >> shamt_x;
         OP_SRA:  o_result_x = $signed(a_x) >>> shamt_x;
         OP_JAL:  o_result_x = {pc_next_x, 1'b0};          // Link value
         default: o_result_x = '0;                          // Branches write nothing
      endcase
   end

   always_comb begin
      is_branch_x = 1'b1;
      case (op_x)
         OP_BEQ:  taken_x = eq_x;
         OP_BNE:  taken_x = ~eq_x;
         OP_BLT:  taken_x = lt_x;
         OP_BGE:  taken_x = ~lt_x;
         OP_JAL:  taken_x = 1'b1;
         default: begin
            taken_x     = 1'b0;
            is_branch_x = 1'b0;
         end
      endcase
   end

   assign br_valid_x   = valid_x & is_branch_x;
   assign mispredict_x = taken_x ^ pred_taken_x;

   assign o_pc_x          = pc_x;
   assign o_br_valid_x    = br_valid_x;
   assign o_br_taken_x    = br_valid_x & taken_x;
   assign o_flush_upper_x = br_valid_x & mispredict_x & ~i_flush_lower;
   assign o_flush_path_x  = taken_x ? target_x : pc_next_x;

   a_flush_needs_valid: assert property (
      @(posedge clk) disable iff (i_reset) o_flush_upper_x |-> valid_x);

   a_reset_clears_valid: assert property (
      @(posedge clk) i_reset |=> !valid_x);

endmodule

//--- hw/exu_mul.sv
`timescale 1ns/10ps

module exu_mul (
   input  logic              clk,
   input  logic              i_reset,
   input  exu_pkg::mul_pkt_t i_mul,
   input  exu_pkg::data_t    i_rs1,
   input  exu_pkg::data_t    i_rs2,
   output logic              o_valid_x,
   output exu_pkg::data_t    o_result_x
);

   import exu_pkg::*;

   mul_pkt_t               mul_x;
   data_t                  rs1_g;
   data_t                  rs2_g;
   logic signed [XLEN:0]   rs1_ext;
   logic signed [XLEN:0]   rs2_ext;
   logic signed [XLEN:0]   a_x;
   logic signed [XLEN:0]   b_x;
   logic signed [2*XLEN+1:0] prod_x;

   assign rs1_g   = i_rs1 & {XLEN{i_mul.valid}};         // Quiet operands when idle
   assign rs2_g   = i_rs2 & {XLEN{i_mul.valid}};
   assign rs1_ext = {i_mul.rs1_sign & rs1_g[XLEN-1], rs1_g};
   assign rs2_ext = {i_mul.rs2_sign & rs2_g[XLEN-1], rs2_g};

   always_ff @(posedge clk) begin
      if (i_reset) begin
         mul_x <= '0;
      end else begin
         mul_x <= i_mul.valid ? i_mul : '0;
      end
   end

   always_ff @(posedge clk) begin
      a_x <= rs1_ext;
      b_x <= rs2_ext;
   end

   assign prod_x     = a_x * b_x;                          // 33 x 33 signed
   assign o_valid_x  = mul_x.valid;
   assign o_result_x = mul_x.low ? prod_x[XLEN-1:0] : prod_x[2*XLEN-1:XLEN];

endmodule

//--- hw/exu_branch_track.sv
`timescale 1ns/10ps

module exu_branch_track (
   input  logic                clk,
   input  logic                i_reset,
   input  logic                i_br_valid_x,
   input  logic                i_br_taken_x,
   input  logic                i_flush_upper_x,
   input  logic                i_flush_lower,
   output exu_pkg::br_report_t o_report_r
);

   import exu_pkg::*;

   ghr_t ghr_x;
   ghr_t ghr_ns;
   logic update_x;

   // A lower flush kills the X branch, history stays put
   assign update_x = i_br_valid_x & ~i_flush_lower;
   assign ghr_ns   = update_x ? {ghr_x[GHR_SIZE-2:0], i_br_taken_x} : ghr_x;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         ghr_x <= '0;
      end else begin
         ghr_x <= ghr_ns;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_report_r <= '0;
      end else begin
         o_report_r.valid      <= update_x;
         o_report_r.taken      <= update_x & i_br_taken_x;
         o_report_r.mispredict <= update_x & i_flush_upper_x;
         o_report_r.ghr        <= ghr_ns;            // Post-update history
      end
   end

   // The upper flush only ever comes from a branch the tracker also sees
   a_flush_from_branch: assert property (
      @(posedge clk) disable iff (i_reset) i_flush_upper_x |-> i_br_valid_x);

endmodule

//--- hw/exu_top.sv
`timescale 1ns/10ps

module exu_top (
   input  logic                 clk,
   input  logic                 i_reset,
   input  exu_pkg::alu_pkt_t    i_alu,
   input  exu_pkg::mul_pkt_t    i_mul,
   input  exu_pkg::opnd_ctl_t   i_opnd,
   input  exu_pkg::data_t       i_gpr_rs1,
   input  exu_pkg::data_t       i_gpr_rs2,
   input  exu_pkg::data_t       i_immed,
   input  exu_pkg::pc_t         i_pc,
   input  exu_pkg::brimm_t      i_br_immed,
   input  exu_pkg::data_t       i_result_r,
   input  exu_pkg::data_t       i_lsu_result_m,
   input  logic                 i_flush_lower,       // Trap unit flush
   input  exu_pkg::pc_t         i_flush_lower_path,
   output exu_pkg::data_t       o_result_x,
   output exu_pkg::pc_t         o_pc_x,
   output logic                 o_flush_final,
   output exu_pkg::pc_t         o_flush_path_final,
   output exu_pkg::br_report_t  o_br_report_r
);

   import exu_pkg::*;

   data_t rs1_d;
   data_t rs2_d;
   data_t alu_result_x;
   data_t mul_result_x;
   data_t result_x;
   logic  mul_valid_x;
   logic  br_valid_x;
   logic  br_taken_x;
   logic  flush_upper_x;
   pc_t   flush_path_x;

   exu_operand_sel u_opnd (
      .i_opnd         (i_opnd),
      .i_gpr_rs1      (i_gpr_rs1),
      .i_gpr_rs2      (i_gpr_rs2),
      .i_immed        (i_immed),
      .i_result_r     (i_result_r),
      .i_lsu_result_m (i_lsu_result_m),
      .i_result_x     (result_x),                     // X-stage forward
      .i_pc           (i_pc),
      .o_rs1          (rs1_d),
      .o_rs2          (rs2_d)
   );

   exu_alu u_alu (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_alu           (i_alu),
      .i_rs1           (rs1_d),
      .i_rs2           (rs2_d),
      .i_pc            (i_pc),
      .i_br_immed      (i_br_immed),
      .i_flush_lower   (i_flush_lower),
      .o_result_x      (alu_result_x),
      .o_pc_x          (o_pc_x),
      .o_br_valid_x    (br_valid_x),
      .o_br_taken_x    (br_taken_x),
      .o_flush_upper_x (flush_upper_x),
      .o_flush_path_x  (flush_path_x)
   );

   exu_mul u_mul (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_mul      (i_mul),
      .i_rs1      (rs1_d),
      .i_rs2      (rs2_d),
      .o_valid_x  (mul_valid_x),
      .o_result_x (mul_result_x)
   );

   exu_branch_track u_br_track (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_br_valid_x    (br_valid_x),
      .i_br_taken_x    (br_taken_x),
      .i_flush_upper_x (flush_upper_x),
      .i_flush_lower   (i_flush_lower),
      .o_report_r      (o_br_report_r)
   );

   assign result_x   = mul_valid_x ? mul_result_x : alu_result_x;
   assign o_result_x = result_x;

   // Lower flush is older and wins the redirect
   assign o_flush_final      = i_flush_lower | flush_upper_x;
   assign o_flush_path_final = ({31{i_flush_lower}} & i_flush_lower_path) |
                               ({31{~i_flush_lower & flush_upper_x}} & flush_path_x);

   a_one_unit_in_d: assert property (
      @(posedge clk) disable iff (i_reset) !(i_alu.valid && i_mul.valid));

endmodule

//--- verif/exu_checker.sv
`timescale 1ns/10ps

module exu_checker (
   input  logic                clk,
   input  logic                i_reset,
   input  exu_pkg::alu_pkt_t   i_alu,
   input  exu_pkg::mul_pkt_t   i_mul,
   input  exu_pkg::opnd_ctl_t  i_opnd,
   input  exu_pkg::data_t      i_gpr_rs1,
   input  exu_pkg::data_t      i_gpr_rs2,
   input  exu_pkg::data_t      i_immed,
   input  exu_pkg::pc_t        i_pc,
   input  exu_pkg::data_t      i_result_r,
   input  exu_pkg::data_t      i_lsu_result_m,
   input  logic                i_flush_lower,
   input  logic                i_row_valid,     // Row in D this cycle
   input  logic                i_exp_flush,
   input  exu_pkg::pc_t        i_exp_path,
   input  exu_pkg::data_t      i_result_x,
   input  exu_pkg::pc_t        i_pc_x,
   input  logic                i_flush_final,
   input  exu_pkg::pc_t        i_flush_path_final,
   input  exu_pkg::br_report_t i_report_r,
   output int                  o_rows_done,
   output int                  o_errors
);

   import exu_pkg::*;

   typedef struct packed {
      logic [15:0] row;
      logic        chk_res;
      data_t       exp_res;
      pc_t         pc;                          // PC seen in D
      logic        br;
      logic        taken;
      logic        pred;
      logic        exp_flush;
      pc_t         exp_path;
   } entry_t;

   entry_t     q[$];
   entry_t     e;
   entry_t     n;
   br_report_t r_exp;
   logic       r_pend;
   logic [15:0] r_row;
   logic       r_bad;
   logic       cur_bad;
   logic       after_rst;
   ghr_t       ghr_m;
   data_t      prev_exp;                        // Model of the X forward
   data_t      a;
   data_t      b;
   int         row_cnt;

   function automatic data_t pick_byp(byp_sel_t s, data_t reg_val, logic en, data_t dflt);
      if (s[BYP_R]) return i_result_r;
      if (s[BYP_LSU_M]) return i_lsu_result_m;
      if (s[BYP_X]) return prev_exp;
      return en ? reg_val : dflt;
   endfunction

   function automatic data_t alu_model(alu_op_t op, data_t x, data_t y, pc_t pc);
      case (op)
         OP_ADD:  return x + y;
         OP_SUB:  return x - y;
         OP_AND:  return x & y;
         OP_OR:   return x | y;
         OP_XOR:  return x ^ y;
         OP_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         OP_SLTU: return (x < y) ? 32'd1 : 32'd0;
         OP_SLL:  return x << y[4:0];
         OP_SRL:  return x >> y[4:0];
         OP_SRA:  return $signed(x) >>> y[4:0];
         OP_JAL:  return {pc, 1'b0} + 32'd4;   // Return address
         default: return 32'd0;
      endcase
   endfunction

   function automatic data_t mul_model(mul_pkt_t m, data_t x, data_t y);
      logic [63:0] xe;
      logic [63:0] ye;
      logic [63:0] p;
      xe = {{32{m.rs1_sign & x[31]}}, x};
      ye = {{32{m.rs2_sign & y[31]}}, y};
      p  = xe * ye;                              // Mod 2^64 covers mixed signs
      return m.low ? p[31:0] : p[63:32];
   endfunction

   task automatic check_val(input string name, input logic [63:0] ex, input logic [63:0] ac);
      if (ex !== ac) begin
         $display("Error at %0t: %s expected %h actual %h", $time, name, ex, ac);
         cur_bad = 1'b1;
         o_errors++;
      end
   endtask

   initial begin
      o_rows_done = 0;
      o_errors    = 0;
      row_cnt     = 0;
      prev_exp    = '0;
   end

   always @(posedge clk) begin
      if (i_reset) begin
         q.delete();
         r_pend    = 1'b0;
         ghr_m     = '0;
         after_rst = 1'b1;
      end else begin
         cur_bad = 1'b0;
         if (after_rst) begin
            check_val("o_br_report_r", '0, i_report_r);
            check_val("o_flush_final", 0, i_flush_final);
            after_rst = 1'b0;
         end
         // R stage of the row before
         if (r_pend) begin
            check_val("o_br_report_r", r_exp, i_report_r);
            $display("row %0d %s", r_row, (r_bad | cur_bad) ? "failed" : "passed");
            o_rows_done++;
            r_pend  = 1'b0;
            cur_bad = 1'b0;
         end
         if (q.size() > 0) begin
            e = q.pop_front();
            if (e.chk_res) check_val("o_result_x", e.exp_res, i_result_x);
            check_val("o_pc_x", e.pc, i_pc_x);
            check_val("o_flush_final", e.exp_flush, i_flush_final);
            if (e.exp_flush) check_val("o_flush_path_final", e.exp_path, i_flush_path_final);
            r_exp.valid      = e.br & ~i_flush_lower;
            r_exp.taken      = r_exp.valid & e.taken;
            r_exp.mispredict = r_exp.valid & (e.taken ^ e.pred);
            if (r_exp.valid) ghr_m = {ghr_m[GHR_SIZE-2:0], e.taken};
            r_exp.ghr = ghr_m;
            r_row     = e.row;
            r_bad     = cur_bad;
            r_pend    = 1'b1;
         end
         // D stage operands by the selection rules
         a = pick_byp(i_opnd.rs1_byp, i_gpr_rs1, i_opnd.rs1_en, '0);
         if (~|i_opnd.rs1_byp && i_opnd.select_pc) a = {i_pc, 1'b0};
         b = pick_byp(i_opnd.rs2_byp, i_gpr_rs2, i_opnd.rs2_en, i_immed);
         n.exp_res = i_mul.valid ? mul_model(i_mul, a, b) : alu_model(i_alu.op, a, b, i_pc);
         if (i_row_valid) begin
            n.row       = row_cnt[15:0];
            n.chk_res   = i_alu.valid | i_mul.valid;
            n.pc        = i_pc;
            n.br        = i_alu.valid && (i_alu.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL});
            n.taken     = (i_alu.op == OP_JAL) ||
                          (i_alu.op == OP_BEQ && a == b) || (i_alu.op == OP_BNE && a != b) ||
                          (i_alu.op == OP_BLT && $signed(a) < $signed(b)) ||
                          (i_alu.op == OP_BGE && $signed(a) >= $signed(b));
            n.pred      = i_alu.pred_taken;
            n.exp_flush = i_exp_flush;
            n.exp_path  = i_exp_path;
            q.push_back(n);
            row_cnt++;
         end
         prev_exp = n.exp_res;
      end
   end

endmodule

//--- verif/tb_exu.sv
`timescale 1ns/10ps

module tb_exu;

   import exu_pkg::*;

   typedef struct packed {
      alu_pkt_t  alu;
      mul_pkt_t  mul;
      opnd_ctl_t opnd;
      data_t     rs1;
      data_t     rs2;
      data_t     imm;
      brimm_t    brimm;
      logic      rnd;                            // Replace data with random values
      logic      fl_low;                         // Lower flush in this row's X cycle
      pc_t       fl_path;
      logic      exp_flush;
      pc_t       exp_path;
   } row_t;

   localparam pc_t BR_PC = 31'h0000_0400;

   logic clk = 1'b0;
   logic i_reset;
   alu_pkt_t alu;
   mul_pkt_t mul;
   opnd_ctl_t opnd;
   data_t gpr1;
   data_t gpr2;
   data_t imm;
   data_t res_r;
   data_t lsu_m;
   data_t result_x;
   pc_t pc;
   pc_t fl_path;
   pc_t exp_path;
   pc_t pc_x;
   pc_t flush_path;
   brimm_t brimm;
   logic fl_low;
   logic row_valid;
   logic exp_flush;
   logic flush_final;
   br_report_t report;
   row_t rows[$];
   row_t r;
   int rows_done;
   int errors;
   int cycles;
   int limit;

   always #5 clk = ~clk;

   exu_top DUT (
      .clk(clk), .i_reset(i_reset), .i_alu(alu), .i_mul(mul), .i_opnd(opnd),
      .i_gpr_rs1(gpr1), .i_gpr_rs2(gpr2), .i_immed(imm), .i_pc(pc), .i_br_immed(brimm),
      .i_result_r(res_r), .i_lsu_result_m(lsu_m), .i_flush_lower(fl_low),
      .i_flush_lower_path(fl_path), .o_result_x(result_x), .o_pc_x(pc_x),
      .o_flush_final(flush_final), .o_flush_path_final(flush_path), .o_br_report_r(report)
   );

   exu_checker u_chk (
      .clk(clk), .i_reset(i_reset), .i_alu(alu), .i_mul(mul), .i_opnd(opnd),
      .i_gpr_rs1(gpr1), .i_gpr_rs2(gpr2), .i_immed(imm), .i_pc(pc), .i_result_r(res_r),
      .i_lsu_result_m(lsu_m), .i_flush_lower(fl_low), .i_row_valid(row_valid),
      .i_exp_flush(exp_flush), .i_exp_path(exp_path), .i_result_x(result_x),
      .i_pc_x(pc_x), .i_flush_final(flush_final), .i_flush_path_final(flush_path),
      .i_report_r(report), .o_rows_done(rows_done), .o_errors(errors)
   );

   function automatic opnd_ctl_t ctl(byp_sel_t b1, byp_sel_t b2, logic e1, logic e2, logic sp);
      return '{rs1_byp: b1, rs2_byp: b2, rs1_en: e1, rs2_en: e2, select_pc: sp};
   endfunction

   task automatic add_alu(alu_op_t op, opnd_ctl_t c, data_t a, data_t b, data_t i, logic rnd);
      rows.push_back('{alu: '{1'b1, op, 1'b0}, mul: '0, opnd: c, rs1: a, rs2: b, imm: i,
                       brimm: '0, rnd: rnd, fl_low: 1'b0, fl_path: '0, exp_flush: 1'b0,
                       exp_path: '0});
   endtask

   task automatic add_mul(logic s1, logic s2, logic low, data_t a, data_t b, logic rnd);
      rows.push_back('{alu: '0, mul: '{1'b1, s1, s2, low}, opnd: ctl(0, 0, 1, 1, 0), rs1: a,
                       rs2: b, imm: '0, brimm: '0, rnd: rnd, fl_low: 1'b0, fl_path: '0,
                       exp_flush: 1'b0, exp_path: '0});
   endtask

   task automatic add_br(alu_op_t op, logic pred, data_t a, data_t b, brimm_t bi,
                         logic ef, pc_t ep, logic fl, pc_t fp);
      rows.push_back('{alu: '{1'b1, op, pred}, mul: '0, opnd: ctl(0, 0, 1, 1, 0), rs1: a,
                       rs2: b, imm: '0, brimm: bi, rnd: 1'b0, fl_low: fl, fl_path: fp,
                       exp_flush: ef, exp_path: ep});
   endtask

   task automatic build_table();
      opnd_ctl_t rr;
      rr = ctl(0, 0, 1, 1, 0);
      add_alu(OP_ADD, rr, 32'h7fff_ffff, 32'h1, 0, 0);
      add_alu(OP_SUB, rr, 32'h5, 32'h9, 0, 0);
      add_alu(OP_AND, rr, 0, 0, 0, 1);
      add_alu(OP_OR, rr, 0, 0, 0, 1);
      add_alu(OP_XOR, rr, 0, 0, 0, 1);
      add_alu(OP_SLT, rr, 32'hffff_fff0, 32'h3, 0, 0);
      add_alu(OP_SLTU, rr, 32'hffff_fff0, 32'h3, 0, 0);
      add_alu(OP_SLL, rr, 32'h8000_0001, 32'h24, 0, 0);       // Shift uses five bits
      add_alu(OP_SRL, rr, 32'h8000_0000, 32'h1f, 0, 0);
      add_alu(OP_SRA, rr, 32'h8000_0000, 32'h4, 0, 0);
      add_alu(OP_ADD, ctl(3'b100, 0, 0, 1, 0), 0, 32'h10, 0, 0);  // rs1 from X
      add_alu(OP_XOR, ctl(0, 3'b100, 1, 0, 0), 32'hff, 0, 0, 0);  // rs2 from X
      add_alu(OP_ADD, ctl(3'b001, 3'b010, 0, 0, 0), 0, 0, 0, 0);  // R and LSU sources
      add_alu(OP_OR, ctl(3'b010, 0, 1, 1, 0), 0, 0, 0, 1);
      add_alu(OP_SUB, ctl(0, 0, 0, 0, 1), 32'hdead, 0, 32'h40, 0);   // PC and immediate
      add_alu(OP_ADD, ctl(0, 0, 0, 0, 0), 32'hbeef, 32'h1, 32'h77, 0);
      add_mul(1, 1, 0, 32'hffff_fffe, 32'h3, 0);
      add_mul(0, 0, 0, 32'hffff_fffe, 32'h3, 0);
      add_mul(1, 0, 0, 32'hffff_fffe, 32'hffff_ffff, 0);
      add_mul(0, 1, 0, 32'h7, 32'h8000_0000, 0);
      add_mul(1, 1, 1, 0, 0, 1);
      add_mul(0, 0, 0, 0, 0, 1);
      add_alu(OP_ADD, ctl(3'b100, 0, 0, 1, 0), 0, 32'h1, 0, 0);   // Product forward
      add_br(OP_BEQ, 1, 5, 5, 12'h010, 0, 0, 0, 0);
      add_br(OP_BNE, 1, 5, 5, 12'h010, 1, BR_PC + 31'd2, 0, 0);
      add_br(OP_BLT, 0, 32'hffff_ffff, 1, 12'h010, 1, BR_PC + 31'h10, 0, 0);
      add_br(OP_BGE, 0, 32'hffff_ffff, 1, 12'h010, 0, 0, 0, 0);
      add_br(OP_JAL, 1, 0, 0, 12'h020, 0, 0, 0, 0);
      add_br(OP_JAL, 0, 0, 0, 12'hff0, 1, BR_PC - 31'h10, 0, 0);
      add_br(OP_BNE, 0, 1, 2, 12'h010, 1, 31'h0000_1000, 1, 31'h0000_1000);
      add_br(OP_BEQ, 1, 3, 3, 12'h010, 0, 0, 0, 0);
   endtask

   // Idle inputs; a lower flush belongs to the row now in X
   task automatic drive_idle(logic fl, pc_t fp);
      alu       = '0;
      mul       = '0;
      opnd      = '0;
      gpr1      = '0;
      gpr2      = '0;
      imm       = '0;
      pc        = BR_PC;
      brimm     = '0;
      row_valid = 1'b0;
      exp_flush = 1'b0;
      exp_path  = '0;
      fl_low    = fl;
      fl_path   = fp;
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout: the checker did not finish all %0d rows", rows.size());
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      cycles = 0;
      limit  = 1000;
      void'($urandom(32'h2971_175d));
      i_reset = 1'b1;
      res_r = 32'ha500_0000;
      lsu_m = 32'h5a00_0000;
      drive_idle(0, '0);
      build_table();
      limit = rows.size() + 5 + 20;
      repeat (5) @(posedge clk);
      #1 i_reset = 1'b0;
      @(posedge clk);
      for (int k = 0; k < rows.size(); k++) begin
         #1;
         r = rows[k];
         if (r.rnd) begin
            r.rs1 = $urandom;
            r.rs2 = $urandom;
            r.imm = $urandom;
         end
         drive_idle(k > 0 ? rows[k-1].fl_low : 1'b0, k > 0 ? rows[k-1].fl_path : '0);
         if (!(r.alu.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL})) begin
            pc = BR_PC + 31'(k * 8);                 // Own PC for each non-branch row
         end
         alu       = r.alu;
         mul       = r.mul;
         opnd      = r.opnd;
         gpr1      = r.rs1;
         gpr2      = r.rs2;
         imm       = r.imm;
         brimm     = r.brimm;
         row_valid = 1'b1;
         exp_flush = r.exp_flush;
         exp_path  = r.exp_path;
         res_r     = 32'ha500_0000 | k;
         lsu_m     = 32'h5a00_0000 | (k << 4);
         @(posedge clk);
      end
      #1 drive_idle(rows[rows.size()-1].fl_low, rows[rows.size()-1].fl_path);
      @(posedge clk);
      #1 drive_idle(0, '0);
      wait (rows_done == rows.size());
      @(posedge clk);
      $display("rows %0d, errors %0d", rows_done, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
hw/exu_pkg.sv
hw/exu_operand_sel.sv
hw/exu_alu.sv
hw/exu_mul.sv
hw/exu_branch_track.sv
hw/exu_top.sv
verif/exu_checker.sv
verif/tb_exu.sv

//--- Bender.yml
package:
  name: exu

sources:
  - hw/exu_pkg.sv
  - hw/exu_operand_sel.sv
  - hw/exu_alu.sv
  - hw/exu_mul.sv
  - hw/exu_branch_track.sv
  - hw/exu_top.sv
  - target: test
    files:
      - verif/exu_checker.sv
      - verif/tb_exu.sv
